//--- logic/zx_defs.svh
/* Widths, page and bank numbers, and audio levels for the Spectrum memory and port logic.
   Included by the package and by every module that sizes a port with these values */
`ifndef ZX_DEFS_SVH
`define ZX_DEFS_SVH

// Bus and memory geometry
`define ZX_ADDR_W           16
`define ZX_DATA_W           8
`define ZX_OFFS_W           14
`define ZX_PAGE_W           4
`define ZX_BANK_W           3
`define ZX_NUM_PAGES        10
`define ZX_SCR_W            13

// Physical pages 0 to 7 are the RAM banks, the ROMs sit above them
`define ZX_ROM0_PAGE        8
`define ZX_ROM1_PAGE        9

// Banks with a fixed role in the 128K map
`define ZX_SCREEN_BANK      5
`define ZX_SHADOW_BANK      7
`define ZX_FIXED_BANK_4000  5
`define ZX_FIXED_BANK_8000  2

// ULA output port
`define ZX_BORDER_W         3
`define ZX_AUDIO_W          16
`define ZX_EAR_LEVEL        16'h4000
`define ZX_MIC_LEVEL        16'h1000

// Floating bus value seen by every IO read
`define ZX_IO_IDLE          8'hFF

`endif

//--- logic/zx_pkg.sv
/* Bus, paging and physical memory types shared by the Spectrum memory modules.
   Modules refer to these by scoped name */
`default_nettype none
`include "zx_defs.svh"

package zx_pkg;

	// ==================================================
	// Wishbone classic bus toward the CPU side
	// ==================================================

	typedef struct packed {
		logic                  cyc;
		logic                  stb;
		logic                  we;
		logic                  tga_io;
		logic [`ZX_ADDR_W-1:0] adr;
		logic [`ZX_DATA_W-1:0] dat;
	} wb_req_t;

	typedef struct packed {
		logic                  ack;
		logic [`ZX_DATA_W-1:0] dat;
	} wb_rsp_t;

	// Memory access once the handshake has been decoded
	typedef struct packed {
		logic                  rd;
		logic                  wr;
		logic [`ZX_ADDR_W-1:0] adr;
		logic [`ZX_DATA_W-1:0] dat;
	} mem_req_t;

	// ==================================================
	// IO byte, decoded by 7FFD or by the ULA port
	// ==================================================

	typedef struct packed {
		logic [1:0]            spare;
		logic                  lock;
		logic                  rom_sel;
		logic                  scr_sel;
		logic [`ZX_BANK_W-1:0] bank;
	} paging_view_t;

	typedef struct packed {
		logic [2:0]              spare;
		logic                    ear;
		logic                    mic;
		logic [`ZX_BORDER_W-1:0] border;
	} ula_view_t;

	typedef union packed {
		paging_view_t paging;
		ula_view_t    ula;
	} io_byte_u;

	typedef struct packed {
		logic                  strobe;
		logic [`ZX_ADDR_W-1:0] port;
		io_byte_u              data;
	} io_wr_t;

	// ==================================================
	// Physical side
	// ==================================================

	typedef struct packed {
		logic [`ZX_PAGE_W-1:0] page;
		logic [`ZX_OFFS_W-1:0] offset;
	} phys_addr_t;

	// Bulk loader writes straight into physical pages
	typedef struct packed {
		logic                  active;
		logic                  we;
		phys_addr_t            addr;
		logic [`ZX_DATA_W-1:0] dat;
	} load_req_t;

	typedef struct packed {
		logic                  rd;
		logic                  we;
		phys_addr_t            addr;
		logic [`ZX_DATA_W-1:0] dat;
	} ram_port_t;

endpackage

`default_nettype wire

//--- logic/cpu_bus_port.sv
/* Wishbone classic slave for the CPU side. Turns bus cycles into memory strobes
   and IO write pulses, and answers with a one-cycle ack */
`timescale 1ns/1ps
`default_nettype none
`include "zx_defs.svh"

module cpu_bus_port (
	input  wire                   clk_sys,
	input  wire                   reset,
	input  wire zx_pkg::wb_req_t  bus,
	output zx_pkg::wb_rsp_t       bus_rsp,
	input  wire                   hold,
	output zx_pkg::mem_req_t      mem_req,
	output zx_pkg::io_wr_t        io_wr,
	input  wire [`ZX_DATA_W-1:0]  ram_dout
);

	logic active;
	logic pend;
	logic ack;

	assign active = bus.cyc & bus.stb;

	// First sampled cycle arms pend, the second one acks
	// Any hold cycle drops the arm so the access starts over after the load
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			pend <= 1'b0;
		end else begin
			pend <= active & ~hold & ~pend;
		end
	end

	assign ack = pend & ~hold;

	// ==================================================
	// Strobes toward the paging unit
	// ==================================================

	// Read issued in the first cycle so the RAM data lands with ack
	always_comb begin
		mem_req.rd  = active & ~pend & ~bus.tga_io & ~bus.we;
		mem_req.wr  = ack & ~bus.tga_io & bus.we;
		mem_req.adr = bus.adr;
		mem_req.dat = bus.dat;
	end

	always_comb begin
		io_wr.strobe = ack & bus.tga_io & bus.we;
		io_wr.port   = bus.adr;
		io_wr.data   = bus.dat;
	end

	// IO reads see the idle bus
	always_comb begin
		bus_rsp.ack = ack;
		bus_rsp.dat = bus.tga_io ? `ZX_IO_IDLE : ram_dout;
	end

	// Master must keep its request up through the ack cycle
	ack_within_cycle: assert property (
		@(posedge clk_sys) disable iff (reset)
		bus_rsp.ack |-> (bus.cyc && bus.stb)
	) else $error("ack raised outside an active bus cycle");

endmodule

`default_nettype wire

//--- logic/paging_unit.sv
/* 128K paging register at port 7FFD with lock and 48K mode, and the map from CPU
   addresses to physical pages. The bulk loader takes over the RAM port while active */
`timescale 1ns/1ps
`default_nettype none
`include "zx_defs.svh"

module paging_unit (
	input  wire                    clk_sys,
	input  wire                    reset,
	input  wire                    mode_48k,
	input  wire zx_pkg::mem_req_t  mem_req,
	input  wire zx_pkg::io_wr_t    io_wr,
	input  wire zx_pkg::load_req_t load,
	output zx_pkg::ram_port_t      ram_port,
	output logic                   scr_sel
);

	logic                  zx48;
	zx_pkg::io_byte_u      page_reg;
	logic                  locked;
	logic                  page_write;
	logic                  rom_window;
	logic [`ZX_PAGE_W-1:0] rom_page;
	logic [`ZX_PAGE_W-1:0] cpu_page;

	// ==================================================
	// 7FFD register
	// ==================================================

	assign locked = page_reg.paging.lock | zx48;

	// Partial decode on A15 and A1 low
	assign page_write = io_wr.strobe & ~io_wr.port[15] & ~io_wr.port[1] & ~locked;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			zx48     <= mode_48k;
			page_reg <= '0;
		end else if (page_write) begin
			page_reg <= io_wr.data;
		end
	end

	assign scr_sel = page_reg.paging.scr_sel;

	// ==================================================
	// Address map
	// ==================================================

	assign rom_page = (zx48 | page_reg.paging.rom_sel) ? `ZX_PAGE_W'(`ZX_ROM1_PAGE)
	                                                    : `ZX_PAGE_W'(`ZX_ROM0_PAGE);

	assign rom_window = (mem_req.adr[`ZX_ADDR_W-1 -: 2] == 2'b00);

	always_comb begin
		case (mem_req.adr[`ZX_ADDR_W-1 -: 2])
			2'b00:   cpu_page = rom_page;
			2'b01:   cpu_page = `ZX_PAGE_W'(`ZX_FIXED_BANK_4000);
			2'b10:   cpu_page = `ZX_PAGE_W'(`ZX_FIXED_BANK_8000);
			default: cpu_page = `ZX_PAGE_W'(page_reg.paging.bank);
		endcase
	end

	// Loader owns the port while active, CPU writes to ROM fall away
	always_comb begin
		if (load.active) begin
			ram_port.rd   = 1'b0;
			ram_port.we   = load.we;
			ram_port.addr = load.addr;
			ram_port.dat  = load.dat;
		end else begin
			ram_port.rd          = mem_req.rd;
			ram_port.we          = mem_req.wr & ~rom_window;
			ram_port.addr.page   = cpu_page;
			ram_port.addr.offset = mem_req.adr[`ZX_OFFS_W-1:0];
			ram_port.dat         = mem_req.dat;
		end
	end

	// A CPU write that met an active load would be lost in the port mux
	no_write_under_load: assert property (
		@(posedge clk_sys) disable iff (reset)
		load.active |-> !mem_req.wr
	) else $error("CPU write strobe arrived while the loader owned the RAM port");

endmodule

`default_nettype wire

//--- logic/ula_port.sv
/* ULA output port on even IO addresses. Holds border, ear and mic, and mixes a beeper level */
`timescale 1ns/1ps
`default_nettype none
`include "zx_defs.svh"

module ula_port (
	input  wire                   clk_sys,
	input  wire                   reset,
	input  wire zx_pkg::io_wr_t   io_wr,
	output logic [`ZX_BORDER_W-1:0] border,
	output logic [`ZX_AUDIO_W-1:0]  beeper
);

	logic ear;
	logic mic;

	// Only A0 is decoded
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			border <= '0;
			ear    <= 1'b0;
			mic    <= 1'b0;
		end else if (io_wr.strobe & ~io_wr.port[0]) begin
			border <= io_wr.data.ula.border;
			ear    <= io_wr.data.ula.ear;
			mic    <= io_wr.data.ula.mic;
		end
	end

	// Ear dominates, mic adds a small offset
	assign beeper = (ear ? `ZX_EAR_LEVEL : '0) + (mic ? `ZX_MIC_LEVEL : '0);

endmodule

`default_nettype wire

//--- logic/banked_ram.sv
/* Ten 16K physical pages, eight RAM banks plus two ROMs. One read/write port for the
   CPU and loader, one read-only port for the screen in bank 5 or bank 7 */
`timescale 1ns/1ps
`default_nettype none
`include "zx_defs.svh"

module banked_ram (
	input  wire                     clk_sys,
	input  wire zx_pkg::ram_port_t  ram_port,
	output logic [`ZX_DATA_W-1:0]   ram_dout,
	input  wire                     scr_sel,
	input  wire [`ZX_SCR_W-1:0]     scr_addr,
	output logic [`ZX_DATA_W-1:0]   scr_data
);

	localparam int PAGE_BYTES = 1 << `ZX_OFFS_W;
	localparam int DEPTH      = `ZX_NUM_PAGES * PAGE_BYTES;

	logic [`ZX_DATA_W-1:0]           mem [DEPTH];
	logic [`ZX_PAGE_W+`ZX_OFFS_W-1:0] cpu_index;
	logic [`ZX_PAGE_W+`ZX_OFFS_W-1:0] scr_index;
	logic [`ZX_PAGE_W-1:0]           scr_page;

	// Page number lands directly above the offset
	assign cpu_index = ram_port.addr;

	// ==================================================
	// CPU and loader port
	// ==================================================

	always_ff @(posedge clk_sys) begin
		if (ram_port.we) begin
			mem[cpu_index] <= ram_port.dat;
		end else if (ram_port.rd) begin
			ram_dout <= mem[cpu_index];
		end
	end

	// ==================================================
	// Screen port
	// ==================================================

	assign scr_page = scr_sel ? `ZX_PAGE_W'(`ZX_SHADOW_BANK) : `ZX_PAGE_W'(`ZX_SCREEN_BANK);

	// Pixel and attribute data fit in the low 8K of the bank
	assign scr_index = {scr_page, {(`ZX_OFFS_W - `ZX_SCR_W){1'b0}}, scr_addr};

	always_ff @(posedge clk_sys) begin
		scr_data <= mem[scr_index];
	end

endmodule

`default_nettype wire

//--- logic/zx_mem_top.sv
/* Spectrum 128K memory and port subsystem. Wishbone CPU port, paging, ULA port,
   banked RAM with a screen read port, and a bulk load path */
`timescale 1ns/1ps
`default_nettype none
`include "zx_defs.svh"

module zx_mem_top (
	input  wire                     clk_sys,
	input  wire                     reset,
	input  wire zx_pkg::wb_req_t    bus,
	output zx_pkg::wb_rsp_t         bus_rsp,
	input  wire zx_pkg::load_req_t  load,
	input  wire                     mode_48k,
	input  wire [`ZX_SCR_W-1:0]     scr_addr,
	output logic [`ZX_DATA_W-1:0]   scr_data,
	output logic [`ZX_BORDER_W-1:0] border,
	output logic [`ZX_AUDIO_W-1:0]  beeper
);

	zx_pkg::mem_req_t      mem_req;
	zx_pkg::io_wr_t        io_wr;
	zx_pkg::ram_port_t     ram_port;
	logic [`ZX_DATA_W-1:0] ram_dout;
	logic                  scr_sel;

	// Loader back-pressures the CPU for as long as it runs
	cpu_bus_port u_bus (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.bus      (bus),
		.bus_rsp  (bus_rsp),
		.hold     (load.active),
		.mem_req  (mem_req),
		.io_wr    (io_wr),
		.ram_dout (ram_dout)
	);

	paging_unit u_paging (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.mode_48k (mode_48k),
		.mem_req  (mem_req),
		.io_wr    (io_wr),
		.load     (load),
		.ram_port (ram_port),
		.scr_sel  (scr_sel)
	);

	ula_port u_ula (
		.clk_sys (clk_sys),
		.reset   (reset),
		.io_wr   (io_wr),
		.border  (border),
		.beeper  (beeper)
	);

	banked_ram u_ram (
		.clk_sys  (clk_sys),
		.ram_port (ram_port),
		.ram_dout (ram_dout),
		.scr_sel  (scr_sel),
		.scr_addr (scr_addr),
		.scr_data (scr_data)
	);

endmodule

`default_nettype wire

//--- verification/zx_mem_tasks.svh
/* Wishbone master, loader and random number tasks for the memory subsystem testbench.
   Included inside the testbench module, where they drive its signals directly */
`ifndef ZX_MEM_TASKS_SVH
`define ZX_MEM_TASKS_SVH

// One 32-bit xorshift step
function automatic logic [31:0] xorshift32(input logic [31:0] x);
	logic [31:0] y;
	y = x ^ (x << 13);
	y = y ^ (y >> 17);
	y = y ^ (y << 5);
	return y;
endfunction

task automatic random_byte(output logic [7:0] b);
	rng_state = xorshift32(rng_state);
	b = rng_state[7:0];
endtask

// Two rising edges see reset high, release on the falling edge after them
task automatic apply_reset(input logic m48);
	reset    = 1'b1;
	mode_48k = m48;
	repeat (2) @(posedge clk_sys);
	@(negedge clk_sys);
	reset = 1'b0;
endtask

// Single loader write straight into a physical page
task automatic load_byte(input logic [3:0] page, input logic [13:0] offs, input logic [7:0] dat);
	@(negedge clk_sys);
	load.active      = 1'b1;
	load.we          = 1'b1;
	load.addr.page   = page;
	load.addr.offset = offs;
	load.dat         = dat;
	@(negedge clk_sys);
	load = '0;
endtask

// ==================================================
// Wishbone classic master
// ==================================================

// Request stays up until ack, then drops on the next falling edge
// Nonzero hold_cycles starts a loader burst once the slave has armed
task automatic bus_cycle(input logic io, input logic we, input logic [15:0] adr,
		input logic [7:0] dat, input int hold_cycles);
	@(negedge clk_sys);
	bus.cyc    = 1'b1;
	bus.stb    = 1'b1;
	bus.we     = we;
	bus.tga_io = io;
	bus.adr    = adr;
	bus.dat    = dat;
	@(negedge clk_sys);
	if (hold_cycles > 0) begin
		load.active      = 1'b1;
		load.we          = 1'b1;
		load.addr.page   = 4'd3;
		load.addr.offset = 14'h0200;
		load.dat         = 8'h5A;
		repeat (hold_cycles) @(negedge clk_sys);
		load = '0;
	end
	while (!bus_rsp.ack) begin
		@(negedge clk_sys);
	end
	@(negedge clk_sys);
	bus.cyc    = 1'b0;
	bus.stb    = 1'b0;
	bus.we     = 1'b0;
	bus.tga_io = 1'b0;
	accesses   = accesses + 1;
endtask

task automatic cpu_read(input logic [15:0] adr, input logic [7:0] expected, input int hold_cycles);
	exp_rd   = expected;
	rd_check = 1'b1;
	bus_cycle(1'b0, 1'b0, adr, 8'h00, hold_cycles);
	rd_check = 1'b0;
endtask

task automatic cpu_write(input logic [15:0] adr, input logic [7:0] dat);
	bus_cycle(1'b0, 1'b1, adr, dat, 0);
endtask

task automatic port_write(input logic [15:0] port, input logic [7:0] dat);
	bus_cycle(1'b1, 1'b1, port, dat, 0);
endtask

`endif

//--- verification/tb_zx_mem.sv
/* Self-checking testbench for the Spectrum memory subsystem. Drives the CPU bus, the
   loader and the screen port; concurrent assertions compare results with expected values */
`timescale 1ns/1ps
`default_nettype none
`include "zx_defs.svh"

module tb_zx_mem;

	// Bus accesses issued by the stimulus below, ten cycles allowed for each
	localparam int          CYCLE_NS         = 100;
	localparam int          PLANNED_ACCESSES = 36;
	localparam logic [13:0] OFFS             = 14'h0123;

	logic              clk_sys;
	logic              reset;
	zx_pkg::wb_req_t   bus;
	zx_pkg::wb_rsp_t   bus_rsp;
	zx_pkg::load_req_t load;
	logic              mode_48k;
	logic [12:0]       scr_addr;
	logic [7:0]        scr_data;
	logic [2:0]        border;
	logic [15:0]       beeper;

	string       test_name;
	int          errors;
	int          accesses;
	int          i;
	logic [31:0] rng_state;
	logic [7:0]  bank_byte [8];
	logic [7:0]  rom_byte [2];
	logic [7:0]  rb;
	logic        rd_check;
	logic        ula_check;
	logic        scr_check;
	logic [7:0]  exp_rd;
	logic [7:0]  exp_scr;
	logic [2:0]  exp_border;
	logic [15:0] exp_beeper;

	`include "zx_mem_tasks.svh"

	zx_mem_top dut (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.bus      (bus),
		.bus_rsp  (bus_rsp),
		.load     (load),
		.mode_48k (mode_48k),
		.scr_addr (scr_addr),
		.scr_data (scr_data),
		.border   (border),
		.beeper   (beeper)
	);

	initial begin
		clk_sys = 1'b0;
		forever #(CYCLE_NS / 2) clk_sys = ~clk_sys;
	end

	initial begin
		#(PLANNED_ACCESSES * 10 * CYCLE_NS);
		$display("Watchdog expired: a bus access never completed");
		$display("STATUS: FAIL");
		$finish;
	end

	// ==================================================
	// Checks
	// ==================================================

	read_data_ok: assert property (@(posedge clk_sys) disable iff (reset)
		(bus_rsp.ack && rd_check) |-> (bus_rsp.dat == exp_rd))
	else begin
		errors = errors + 1;
		$display("CHECK FAILED %s: expected %02h, actual %02h",
			test_name, exp_rd, $sampled(bus_rsp.dat));
	end

	ack_held_off: assert property (@(posedge clk_sys) disable iff (reset)
		load.active |-> !bus_rsp.ack)
	else begin
		errors = errors + 1;
		$display("%s: ack given while the loader held the bus", test_name);
	end

	single_ack: assert property (@(posedge clk_sys) disable iff (reset)
		bus_rsp.ack |=> !bus_rsp.ack)
	else begin
		errors = errors + 1;
		$display("%s: ack stayed high for more than one cycle", test_name);
	end

	border_ok: assert property (@(posedge clk_sys) disable iff (reset)
		ula_check |-> (border == exp_border))
	else begin
		errors = errors + 1;
		$display("CHECK FAILED %s: expected %0d, actual %0d",
			test_name, exp_border, $sampled(border));
	end

	beeper_ok: assert property (@(posedge clk_sys) disable iff (reset)
		ula_check |-> (beeper == exp_beeper))
	else begin
		errors = errors + 1;
		$display("CHECK FAILED %s: expected %04h, actual %04h",
			test_name, exp_beeper, $sampled(beeper));
	end

	screen_ok: assert property (@(posedge clk_sys) disable iff (reset)
		scr_check |-> (scr_data == exp_scr))
	else begin
		errors = errors + 1;
		$display("CHECK FAILED %s: expected %02h, actual %02h",
			test_name, exp_scr, $sampled(scr_data));
	end

	// Screen data is registered, so the check opens one edge later
	task automatic screen_check(input logic [7:0] expected);
		exp_scr = expected;
		@(negedge clk_sys);
		scr_check = 1'b1;
		@(negedge clk_sys);
		scr_check = 1'b0;
	endtask

	// ==================================================
	// Stimulus
	// ==================================================

	initial begin
		bus       = '0;
		load      = '0;
		mode_48k  = 1'b0;
		scr_addr  = '0;
		rd_check  = 1'b0;
		ula_check = 1'b0;
		scr_check = 1'b0;
		errors    = 0;
		accesses  = 0;
		rng_state = 32'd84;
		test_name = "reset";
		apply_reset(1'b0);

		test_name = "bank_paging";
		for (i = 0; i < 8; i++) begin
			random_byte(bank_byte[i]);
			load_byte(4'(i), OFFS, bank_byte[i]);
		end
		for (i = 0; i < 8; i++) begin
			port_write(16'h7FFD, 8'(i));
			cpu_read({2'b11, OFFS}, bank_byte[i], 0);
		end

		test_name = "fixed_and_rom";
		random_byte(rom_byte[0]);
		load_byte(4'(`ZX_ROM0_PAGE), OFFS, rom_byte[0]);
		random_byte(rom_byte[1]);
		load_byte(4'(`ZX_ROM1_PAGE), OFFS, rom_byte[1]);
		cpu_read({2'b01, OFFS}, bank_byte[5], 0);
		cpu_read({2'b10, OFFS}, bank_byte[2], 0);
		port_write(16'h7FFD, 8'h00);
		cpu_read({2'b00, OFFS}, rom_byte[0], 0);
		port_write(16'h7FFD, 8'h10);
		cpu_read({2'b00, OFFS}, rom_byte[1], 0);
		cpu_write({2'b00, OFFS}, ~rom_byte[1]);
		cpu_read({2'b00, OFFS}, rom_byte[1], 0);

		// Ear and mic walk through all four combinations
		test_name = "ula_port";
		for (i = 0; i < 4; i++) begin
			random_byte(rb);
			rb = {rb[7:5], 2'(i), rb[2:0]};
			port_write(16'h00FE, rb);
			exp_border = rb[2:0];
			exp_beeper = (rb[4] ? `ZX_EAR_LEVEL : 16'h0) + (rb[3] ? `ZX_MIC_LEVEL : 16'h0);
			ula_check  = 1'b1;
			@(negedge clk_sys);
			ula_check = 1'b0;
		end

		test_name = "screen_select";
		scr_addr  = 13'(OFFS);
		screen_check(bank_byte[5]);
		port_write(16'h7FFD, 8'h08);
		screen_check(bank_byte[7]);

		test_name = "back_pressure";
		cpu_read({2'b10, OFFS}, bank_byte[2], 4);

		test_name = "lock";
		port_write(16'h7FFD, 8'h23);
		port_write(16'h7FFD, 8'h06);
		cpu_read({2'b11, OFFS}, bank_byte[3], 0);

		test_name = "mode_48k";
		apply_reset(1'b1);
		cpu_read({2'b00, OFFS}, rom_byte[1], 0);
		port_write(16'h7FFD, 8'h04);
		cpu_read({2'b11, OFFS}, bank_byte[0], 0);

		@(negedge clk_sys);
		$display("Accesses: %0d, errors: %0d", accesses, errors);
		if (errors == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- src.f
+incdir+logic
+incdir+verification
logic/zx_pkg.sv
logic/cpu_bus_port.sv
logic/paging_unit.sv
logic/ula_port.sv
logic/banked_ram.sv
logic/zx_mem_top.sv
verification/tb_zx_mem.sv

//--- run.sh
#!/usr/bin/env bash
# Build the testbench with Verilator, run it, and judge the result from the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_zx_mem \
	-f src.f \
	-o sim_zx_mem

./obj_dir/sim_zx_mem > sim.log 2>&1
cat sim.log

if grep -q "^STATUS: PASS$" sim.log; then
	exit 0
fi
exit 1
